// File: exe_mem_pipe.f
+incdir+include
hdl/cpu_pkg.sv
hdl/exe_mem_if.sv
hdl/alu.sv
hdl/exe_stage.sv
hdl/data_ram.sv
hdl/mem_stage.sv
hdl/exe_mem_pipe.sv
tests/tb_exe_mem_pipe.sv

// File: hdl/alu.sv
// combinational alu for arithmetic, logic and shifts
// o_overflow is the signed overflow flag of add and sub
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::word_t   i_a,
    input  cpu_pkg::word_t   i_b,
    input  cpu_pkg::alu_fn_e i_fn,
    output cpu_pkg::word_t   o_result,
    output logic             o_overflow
);
    import cpu_pkg::*;

    word_t sum;
    word_t diff;

    assign sum  = i_a + i_b;
    assign diff = i_a - i_b;

    always_comb begin
        case (i_fn)
            FN_ADD:  o_result = sum;
            FN_SUB:  o_result = diff;
            FN_AND:  o_result = i_a & i_b;
            FN_OR:   o_result = i_a | i_b;
            FN_XOR:  o_result = i_a ^ i_b;
            FN_NOR:  o_result = ~(i_a | i_b);
            // shifts move operand b by the amount in operand a
            FN_SLL:  o_result = i_b << i_a[4:0];
            FN_SRL:  o_result = i_b >> i_a[4:0];
            FN_SRA:  o_result = word_t'($signed(i_b) >>> i_a[4:0]);
            FN_LUI:  o_result = {i_b[15:0], 16'h0000};
            default: o_result = sum;
        endcase
    end

    // add overflows when both inputs share a sign the sum does not have
    // sub overflows when the inputs differ in sign and the result follows b
    always_comb begin
        case (i_fn)
            FN_ADD:  o_overflow = (i_a[31] == i_b[31]) && (sum[31] != i_a[31]);
            FN_SUB:  o_overflow = (i_a[31] != i_b[31]) && (diff[31] != i_a[31]);
            default: o_overflow = 1'b0;
        endcase
    end

endmodule

// File: hdl/cpu_pkg.sv
// shared types and enums for the execute/memory pipeline
// imported by every RTL module and by the testbench
package cpu_pkg;

    // data word, also used for addresses and the pc
    typedef logic [31:0] word_t;
    // register file index
    typedef logic [4:0] reg_idx_t;

    // jal always links into r31
    localparam reg_idx_t LINK_REG = 5'd31;

    // decoded operation, grouped as alu, branch, memory
    typedef enum logic [4:0] {
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_SLT,
        OP_SLTU,
        OP_BEQ,
        OP_BNE,
        OP_BLEZ,
        OP_BGTZ,
        OP_BLTZ,
        OP_BGEZ,
        OP_JAL,
        OP_JR,
        OP_LW,
        OP_LH,
        OP_LHU,
        OP_LB,
        OP_LBU,
        OP_SW,
        OP_SH,
        OP_SB
    } op_e;

    // alu function select
    typedef enum logic [3:0] {
        FN_ADD,
        FN_SUB,
        FN_AND,
        FN_OR,
        FN_XOR,
        FN_NOR,
        FN_SLL,
        FN_SRL,
        FN_SRA,
        FN_LUI
    } alu_fn_e;

    // exception cause reported with the exception strobe
    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_OVERFLOW,
        EXC_MISALIGNED
    } exc_cause_e;

endpackage

// File: hdl/data_ram.sv
// word-organized data memory, asynchronous read and synchronous write
// driven by mem_stage, which does its own byte-lane merge
`timescale 1ns/1ns

module data_ram #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic [$clog2(MEM_WORDS)-1:0] i_addr,
    input  logic                         i_we,
    input  cpu_pkg::word_t               i_wdata,
    output cpu_pkg::word_t               o_rdata
);
    import cpu_pkg::*;

    word_t mem [MEM_WORDS];

    // read in the same cycle as the address
    assign o_rdata = mem[i_addr];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

endmodule

// File: hdl/exe_mem_if.sv
// one executed operation handed from the execute stage to the memory stage
// exe_stage drives through modport exe, mem_stage reads through modport mem
`timescale 1ns/1ns

interface exe_mem_if;
    import cpu_pkg::*;

    // single-cycle strobe per operation
    logic     valid;
    op_e      op;
    // alu / slt / link value, or the memory address
    word_t    result;
    word_t    store_data;
    reg_idx_t rd;
    // cleared on overflow, for stores and plain branches
    logic     wb_en;

    modport exe (
        output valid, op, result, store_data, rd, wb_en
    );

    modport mem (
        input valid, op, result, store_data, rd, wb_en
    );

endinterface

// File: hdl/exe_mem_pipe.sv
// top level of the execute/memory pipeline with plain ports
// writeback at +2 cycles, branch at +1, exceptions at +1 or +2
`timescale 1ns/1ns

module exe_mem_pipe #(
    parameter int MEM_WORDS = 256
) (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_valid,
    input  cpu_pkg::op_e        i_op,
    input  cpu_pkg::word_t      i_da,
    input  cpu_pkg::word_t      i_db,
    input  cpu_pkg::word_t      i_imm,
    input  cpu_pkg::word_t      i_pc,
    input  cpu_pkg::reg_idx_t   i_rd,
    output logic                o_br_valid,
    output logic                o_br_taken,
    output cpu_pkg::word_t      o_br_target,
    output logic                o_wb_valid,
    output cpu_pkg::reg_idx_t   o_wb_rd,
    output cpu_pkg::word_t      o_wb_data,
    output logic                o_exc_valid,
    output cpu_pkg::exc_cause_e o_exc_cause
);
    import cpu_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    logic          ovf_valid;
    exc_cause_e    ovf_cause;
    logic          mis_valid;
    exc_cause_e    mis_cause;
    logic [AW-1:0] ram_addr;
    logic          ram_we;
    word_t         ram_wdata;
    word_t         ram_rdata;

    exe_mem_if em_if ();

    exe_stage exe_stage_i (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_valid     (i_valid),
        .i_op        (i_op),
        .i_da        (i_da),
        .i_db        (i_db),
        .i_imm       (i_imm),
        .i_pc        (i_pc),
        .i_rd        (i_rd),
        .out         (em_if.exe),
        .o_br_valid  (o_br_valid),
        .o_br_taken  (o_br_taken),
        .o_br_target (o_br_target),
        .o_exc_valid (ovf_valid),
        .o_exc_cause (ovf_cause)
    );

    mem_stage #(.MEM_WORDS(MEM_WORDS)) mem_stage_i (
        .clk         (clk),
        .i_reset     (i_reset),
        .in          (em_if.mem),
        .o_ram_addr  (ram_addr),
        .o_ram_we    (ram_we),
        .o_ram_wdata (ram_wdata),
        .i_ram_rdata (ram_rdata),
        .o_wb_valid  (o_wb_valid),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data),
        .o_exc_valid (mis_valid),
        .o_exc_cause (mis_cause)
    );

    data_ram #(.MEM_WORDS(MEM_WORDS)) data_ram_i (
        .clk     (clk),
        .i_addr  (ram_addr),
        .i_we    (ram_we),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

    // a misaligned report from the older op wins over a same-cycle overflow
    assign o_exc_valid = ovf_valid || mis_valid;
    assign o_exc_cause = mis_valid ? mis_cause : ovf_cause;

endmodule

// File: hdl/exe_stage.sv
// execute stage: operand select, alu, set-less-than, link and branch resolve
// everything is registered into exe_mem_if and the branch/exception outputs
`timescale 1ns/1ns

module exe_stage (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_valid,
    input  cpu_pkg::op_e        i_op,
    input  cpu_pkg::word_t      i_da,
    input  cpu_pkg::word_t      i_db,
    input  cpu_pkg::word_t      i_imm,
    input  cpu_pkg::word_t      i_pc,
    input  cpu_pkg::reg_idx_t   i_rd,
    exe_mem_if.exe              out,
    output logic                o_br_valid,
    output logic                o_br_taken,
    output cpu_pkg::word_t      o_br_target,
    output logic                o_exc_valid,
    output cpu_pkg::exc_cause_e o_exc_cause
);
    import cpu_pkg::*;

    alu_fn_e fn;
    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_result;
    logic    alu_ovf;
    word_t   pc4;
    word_t   exe_out;
    logic    is_alu;
    logic    is_branch;
    logic    is_load;
    logic    trap;
    logic    taken;
    word_t   target;

    assign is_alu    = i_op inside {[OP_ADD:OP_SLTU]};
    assign is_branch = i_op inside {[OP_BEQ:OP_JR]};
    assign is_load   = i_op inside {[OP_LW:OP_LBU]};
    assign pc4       = i_pc + 32'd4;

    // opcode to alu function and operand routing
    always_comb begin
        fn    = FN_ADD;
        alu_a = i_da;
        alu_b = i_db;
        case (i_op)
            OP_SUB, OP_SUBU: fn = FN_SUB;
            OP_AND:          fn = FN_AND;
            OP_OR:           fn = FN_OR;
            OP_XOR:          fn = FN_XOR;
            OP_NOR:          fn = FN_NOR;
            OP_LUI:          fn = FN_LUI;
            OP_SLL, OP_SRL, OP_SRA: begin
                // shift amount sits in imm[10:6]
                fn    = (i_op == OP_SLL) ? FN_SLL : (i_op == OP_SRL) ? FN_SRL : FN_SRA;
                alu_a = {27'b0, i_imm[10:6]};
            end
            // address = base + offset
            OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU, OP_SW, OP_SH, OP_SB: alu_b = i_imm;
            default: ;
        endcase
    end

    alu alu_i (
        .i_a        (alu_a),
        .i_b        (alu_b),
        .i_fn       (fn),
        .o_result   (alu_result),
        .o_overflow (alu_ovf)
    );

    // output mux: link, then slt, then plain alu
    always_comb begin
        case (i_op)
            OP_JAL:  exe_out = pc4;
            OP_SLTU: exe_out = {31'b0, i_da < i_db};
            OP_SLT:  exe_out = {31'b0, $signed(i_da) < $signed(i_db)};
            default: exe_out = alu_result;
        endcase
    end

    // only the trapping add and sub raise overflow
    assign trap = i_valid && (i_op inside {OP_ADD, OP_SUB}) && alu_ovf;

    // branch conditions on da (and db for beq/bne)
    always_comb begin
        case (i_op)
            OP_BEQ:          taken = (i_da == i_db);
            OP_BNE:          taken = (i_da != i_db);
            OP_BLEZ:         taken = i_da[31] || (i_da == '0);
            OP_BGTZ:         taken = !i_da[31] && (i_da != '0);
            OP_BLTZ:         taken = i_da[31];
            OP_BGEZ:         taken = !i_da[31];
            OP_JAL, OP_JR:   taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    // jal keeps the pc segment, jr jumps to da
    always_comb begin
        if (i_op == OP_JAL)
            target = {i_pc[31:28], i_imm[25:0], 2'b00};
        else if (i_op == OP_JR)
            target = i_da;
        else if (taken)
            target = pc4 + {i_imm[29:0], 2'b00};
        else
            target = pc4;
    end

    // strobes and cause
    always_ff @(posedge clk) begin
        if (i_reset) begin
            out.valid   <= 1'b0;
            o_br_valid  <= 1'b0;
            o_exc_valid <= 1'b0;
            o_exc_cause <= EXC_NONE;
        end else begin
            out.valid   <= i_valid;
            o_br_valid  <= i_valid && is_branch;
            o_exc_valid <= trap;
            o_exc_cause <= trap ? EXC_OVERFLOW : EXC_NONE;
        end
    end

    // payload, qualified by the strobes above
    always_ff @(posedge clk) begin
        out.op         <= i_op;
        out.result     <= exe_out;
        out.store_data <= i_db;
        out.rd         <= (i_op == OP_JAL) ? LINK_REG : i_rd;
        out.wb_en      <= (is_alu || is_load || i_op == OP_JAL) && !trap;
        o_br_taken     <= taken;
        o_br_target    <= target;
    end

endmodule

// File: hdl/mem_stage.sv
// memory stage: big-endian lane mask/shift, store merge, load extension
// misalign check and the writeback register, one cycle after exe_mem_if
`timescale 1ns/1ns

module mem_stage #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         i_reset,
    exe_mem_if.mem                       in,
    output logic [$clog2(MEM_WORDS)-1:0] o_ram_addr,
    output logic                         o_ram_we,
    output cpu_pkg::word_t               o_ram_wdata,
    input  cpu_pkg::word_t               i_ram_rdata,
    output logic                         o_wb_valid,
    output cpu_pkg::reg_idx_t            o_wb_rd,
    output cpu_pkg::word_t               o_wb_data,
    output logic                         o_exc_valid,
    output cpu_pkg::exc_cause_e          o_exc_cause
);
    import cpu_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    logic       is_load;
    logic       is_store;
    logic       is_word;
    logic       is_half;
    logic       load_sign;
    logic [1:0] offset;
    logic       misaligned;
    logic       mis_exc;
    word_t      mask;
    logic [4:0] shift;
    word_t      load_raw;
    word_t      load_val;
    logic       ext;

    assign is_load   = in.op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
    assign is_store  = in.op inside {OP_SW, OP_SH, OP_SB};
    assign is_word   = in.op inside {OP_LW, OP_SW};
    assign is_half   = in.op inside {OP_LH, OP_LHU, OP_SH};
    assign load_sign = in.op inside {OP_LH, OP_LB};
    assign offset    = in.result[1:0];

    // halfword needs bit 0 clear, word needs both low bits clear
    assign misaligned = (is_half && offset[0]) || (is_word && (offset != 2'b00));
    assign mis_exc    = in.valid && (is_load || is_store) && misaligned;

    // offset 0 is the most significant lane
    always_comb begin
        if (is_half) begin
            mask  = offset[1] ? 32'h0000_ffff : 32'hffff_0000;
            shift = offset[1] ? 5'd0 : 5'd16;
        end else begin
            case (offset)
                2'b00:   mask = 32'hff00_0000;
                2'b01:   mask = 32'h00ff_0000;
                2'b10:   mask = 32'h0000_ff00;
                default: mask = 32'h0000_00ff;
            endcase
            shift = 5'(8 * (3 - offset));
        end
    end

    // word index wraps modulo the ram depth
    assign o_ram_addr = in.result[AW+1:2];
    assign o_ram_we   = in.valid && is_store && !misaligned;

    // sub-word stores merge into the current word
    assign o_ram_wdata = is_word ? in.store_data
                                 : (i_ram_rdata & ~mask) | ((in.store_data << shift) & mask);

    // load lane extract and extension
    assign load_raw = (i_ram_rdata & mask) >> shift;
    assign ext      = load_sign && (is_half ? load_raw[15] : load_raw[7]);

    always_comb begin
        if (is_word)
            load_val = i_ram_rdata;
        else if (is_half)
            load_val = {{16{ext}}, load_raw[15:0]};
        else
            load_val = {{24{ext}}, load_raw[7:0]};
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_wb_valid  <= 1'b0;
            o_exc_valid <= 1'b0;
            o_exc_cause <= EXC_NONE;
        end else begin
            // misaligned access never writes back
            o_wb_valid  <= in.valid && in.wb_en && !((is_load || is_store) && misaligned);
            o_exc_valid <= mis_exc;
            o_exc_cause <= mis_exc ? EXC_MISALIGNED : EXC_NONE;
        end
    end

    // non-memory ops pass the execute result straight on
    always_ff @(posedge clk) begin
        o_wb_rd   <= in.rd;
        o_wb_data <= is_load ? load_val : in.result;
    end

endmodule

// File: include/tb_model.svh
// reference functions for expected alu results, branch targets and loads
// included inside the testbench module
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// expected alu group result, shifts use imm[10:6] on db
function automatic cpu_pkg::word_t model_alu(cpu_pkg::op_e op, cpu_pkg::word_t a,
                                              cpu_pkg::word_t b, cpu_pkg::word_t imm);
    case (op)
        cpu_pkg::OP_ADD, cpu_pkg::OP_ADDU: return a + b;
        cpu_pkg::OP_SUB, cpu_pkg::OP_SUBU: return a - b;
        cpu_pkg::OP_AND:  return a & b;
        cpu_pkg::OP_OR:   return a | b;
        cpu_pkg::OP_XOR:  return a ^ b;
        cpu_pkg::OP_NOR:  return ~(a | b);
        cpu_pkg::OP_SLL:  return b << imm[10:6];
        cpu_pkg::OP_SRL:  return b >> imm[10:6];
        cpu_pkg::OP_SRA:  return $signed(b) >>> imm[10:6];
        cpu_pkg::OP_LUI:  return {b[15:0], 16'h0000};
        cpu_pkg::OP_SLT:  return {31'b0, $signed(a) < $signed(b)};
        cpu_pkg::OP_SLTU: return {31'b0, a < b};
        default:          return '0;
    endcase
endfunction

// signed overflow of the trapping add and sub
function automatic bit model_overflow(cpu_pkg::op_e op, cpu_pkg::word_t a, cpu_pkg::word_t b);
    cpu_pkg::word_t r;
    r = (op == cpu_pkg::OP_SUB) ? a - b : a + b;
    if (op == cpu_pkg::OP_ADD)
        return (a[31] == b[31]) && (r[31] != a[31]);
    if (op == cpu_pkg::OP_SUB)
        return (a[31] != b[31]) && (r[31] != a[31]);
    return 1'b0;
endfunction

// branch target for a known taken/not taken outcome
function automatic cpu_pkg::word_t model_target(cpu_pkg::op_e op, bit taken, cpu_pkg::word_t da,
                                                 cpu_pkg::word_t imm, cpu_pkg::word_t pc);
    if (op == cpu_pkg::OP_JAL)
        return {pc[31:28], imm[25:0], 2'b00};
    if (op == cpu_pkg::OP_JR)
        return da;
    return taken ? pc + 32'd4 + {imm[29:0], 2'b00} : pc + 32'd4;
endfunction

// big-endian load extraction from a stored word
function automatic cpu_pkg::word_t model_load(cpu_pkg::op_e op, cpu_pkg::word_t w, logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[8*(3-off) +: 8];
    h = off[1] ? w[15:0] : w[31:16];
    case (op)
        cpu_pkg::OP_LB:  return {{24{b[7]}}, b};
        cpu_pkg::OP_LBU: return {24'b0, b};
        cpu_pkg::OP_LH:  return {{16{h[15]}}, h};
        cpu_pkg::OP_LHU: return {16'b0, h};
        default:         return w;
    endcase
endfunction

`endif

// File: tests/tb_exe_mem_pipe.sv
// directed testbench for the execute/memory pipeline top level
// every cycle the outputs are compared with the expected results of earlier ops
`timescale 1ns/1ns

module tb_exe_mem_pipe;
    import cpu_pkg::*;

    `include "tb_model.svh"

    // well above the ~180 cycles the tests take
    localparam int TIMEOUT_CYCLES = 2000;

    // what one operation should produce downstream
    typedef struct packed {
        logic     wb;
        reg_idx_t rd;
        word_t    data;
        logic     br;
        logic     taken;
        word_t    target;
        logic     ovf;
        logic     mis;
    } exp_t;

    logic       clk;
    logic       i_reset;
    logic       i_valid;
    op_e        i_op;
    word_t      i_da;
    word_t      i_db;
    word_t      i_imm;
    word_t      i_pc;
    reg_idx_t   i_rd;
    logic       o_br_valid;
    logic       o_br_taken;
    word_t      o_br_target;
    logic       o_wb_valid;
    reg_idx_t   o_wb_rd;
    word_t      o_wb_data;
    logic       o_exc_valid;
    exc_cause_e o_exc_cause;

    integer seed;
    int     cycles;
    string  test_name;
    // s0 = op just driven, s1 = op in exe outputs, s2 = op in writeback outputs
    exp_t   exp_s0;
    exp_t   exp_s1;
    exp_t   exp_s2;

    exe_mem_pipe #(.MEM_WORDS(256)) exe_mem_pipe_i (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_valid     (i_valid),
        .i_op        (i_op),
        .i_da        (i_da),
        .i_db        (i_db),
        .i_imm       (i_imm),
        .i_pc        (i_pc),
        .i_rd        (i_rd),
        .o_br_valid  (o_br_valid),
        .o_br_taken  (o_br_taken),
        .o_br_target (o_br_target),
        .o_wb_valid  (o_wb_valid),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data),
        .o_exc_valid (o_exc_valid),
        .o_exc_cause (o_exc_cause)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d cycles in test %s", TIMEOUT_CYCLES, test_name);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("Simulation failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_rd(input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("ERR %s wb rd: expected %0d, actual %0d", test_name, exp, act);
            $display("Simulation failed");
            $fatal(1, "rd mismatch");
        end
    endtask

    task automatic check_cause(input exc_cause_e exp, input exc_cause_e act);
        if (act !== exp) begin
            $display("ERR %s cause: expected %s, actual %s (%0d)", test_name, exp.name(),
                     act.name(), act);
            $display("Simulation failed");
            $fatal(1, "cause mismatch");
        end
    endtask

    task automatic compare_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
            $display("Simulation failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // a strobe absent when due, or present when nothing is due
    task automatic expect_strobe(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            if (exp)
                $display("%s: %s strobe did not appear at its cycle", test_name, what);
            else
                $display("%s: %s strobe is high when no result is due", test_name, what);
            $display("Simulation failed");
            $fatal(1, "strobe mismatch");
        end
    endtask

    task automatic compare_outputs();
        expect_strobe("branch", exp_s1.br, o_br_valid);
        if (exp_s1.br) begin
            compare_flag("branch taken", exp_s1.taken, o_br_taken);
            check_word("branch target", exp_s1.target, o_br_target);
        end
        expect_strobe("writeback", exp_s2.wb, o_wb_valid);
        if (exp_s2.wb) begin
            check_rd(exp_s2.rd, o_wb_rd);
            check_word("wb data", exp_s2.data, o_wb_data);
        end
        // overflow shows one cycle after acceptance, misalign two
        expect_strobe("exception", exp_s1.ovf || exp_s2.mis, o_exc_valid);
        if (exp_s2.mis)
            check_cause(EXC_MISALIGNED, o_exc_cause);
        else if (exp_s1.ovf)
            check_cause(EXC_OVERFLOW, o_exc_cause);
    endtask

    // drive one cycle of inputs, then check what is due at the falling edge
    task automatic run_cycle(input logic valid, input op_e op, input word_t da, input word_t db,
                             input word_t imm, input word_t pc, input reg_idx_t rd,
                             input exp_t e);
        @(posedge clk);
        i_valid <= valid;
        i_op    <= op;
        i_da    <= da;
        i_db    <= db;
        i_imm   <= imm;
        i_pc    <= pc;
        i_rd    <= rd;
        exp_s2 = exp_s1;
        exp_s1 = exp_s0;
        exp_s0 = e;
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic idle_cycles(input int n);
        for (int k = 0; k < n; k++)
            run_cycle(1'b0, OP_ADD, '0, '0, '0, '0, '0, '0);
    endtask

    // all strobes must stay low while reset is held and until the next op
    task automatic reset_sequence();
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            i_reset <= 1'b1;
            i_valid <= 1'b0;
            @(negedge clk);
            expect_strobe("branch", 1'b0, o_br_valid);
            expect_strobe("writeback", 1'b0, o_wb_valid);
            expect_strobe("exception", 1'b0, o_exc_valid);
        end
        exp_s0 = '0;
        exp_s1 = '0;
        exp_s2 = '0;
        @(posedge clk);
        i_reset <= 1'b0;
        idle_cycles(3);
    endtask

    // alu op with its expected result; trapping overflow suppresses writeback
    task automatic alu_op(input op_e op, input word_t da, input word_t db, input word_t imm,
                          input reg_idx_t rd);
        exp_t e;
        e      = '0;
        e.ovf  = model_overflow(op, da, db);
        e.wb   = !e.ovf;
        e.rd   = rd;
        e.data = model_alu(op, da, db, imm);
        run_cycle(1'b1, op, da, db, imm, '0, rd, e);
    endtask

    // random alu group op whose operands do not overflow
    task automatic random_alu_op();
        op_e      op;
        word_t    da;
        word_t    db;
        word_t    imm;
        reg_idx_t rd;
        op  = op_e'($unsigned($random(seed)) % 14);
        da  = $random(seed);
        db  = $random(seed);
        imm = $random(seed);
        rd  = $random(seed);
        while (model_overflow(op, da, db))
            da = $random(seed);
        alu_op(op, da, db, imm, rd);
    endtask

    task automatic branch_op(input op_e op, input word_t da, input word_t db, input logic taken);
        exp_t  e;
        word_t r;
        word_t imm;
        word_t pc;
        r  = $random(seed);
        pc = $random(seed) & 32'hffff_fffc;
        // conditional offsets are sign-extended 16-bit immediates
        imm      = (op == OP_JAL) ? r : {{16{r[15]}}, r[15:0]};
        e        = '0;
        e.br     = 1'b1;
        e.taken  = taken;
        e.target = model_target(op, taken, da, imm, pc);
        // jal links pc+4 into r31 whatever rd says
        if (op == OP_JAL) begin
            e.wb   = 1'b1;
            e.rd   = LINK_REG;
            e.data = pc + 32'd4;
        end
        run_cycle(1'b1, op, da, db, imm, pc, 5'd9, e);
    endtask

    // load or store; a load expects load_exp unless the access is misaligned
    task automatic mem_op(input op_e op, input word_t base, input word_t imm, input word_t db,
                          input logic misaligned, input word_t load_exp);
        exp_t     e;
        reg_idx_t rd;
        rd     = $random(seed);
        e      = '0;
        e.mis  = misaligned;
        e.wb   = !misaligned && (op >= OP_LW) && (op <= OP_LBU);
        e.rd   = rd;
        e.data = load_exp;
        run_cycle(1'b1, op, base, db, imm, '0, rd, e);
    endtask

    task automatic run_alu_ops();
        test_name = "alu_random";
        for (int k = 0; k < 40; k++) begin
            random_alu_op();
            idle_cycles(1);
        end
        idle_cycles(2);
    endtask

    task automatic overflow_cases();
        test_name = "overflow";
        alu_op(OP_ADD, 32'h7fff_ffff, 32'h0000_0001, '0, 5'd3);
        alu_op(OP_SUB, 32'h8000_0000, 32'h0000_0001, '0, 5'd4);
        // the non-trapping forms wrap and still write back
        alu_op(OP_ADDU, 32'h7fff_ffff, 32'h0000_0001, '0, 5'd5);
        alu_op(OP_SUBU, 32'h8000_0000, 32'h0000_0001, '0, 5'd6);
        idle_cycles(2);
    endtask

    task automatic branch_cases();
        test_name = "branches";
        branch_op(OP_BEQ, 32'd5, 32'd5, 1'b1);
        branch_op(OP_BEQ, 32'd5, 32'd6, 1'b0);
        branch_op(OP_BNE, 32'd5, 32'd6, 1'b1);
        branch_op(OP_BNE, 32'd5, 32'd5, 1'b0);
        branch_op(OP_BLEZ, 32'd0, '0, 1'b1);
        branch_op(OP_BLEZ, 32'd1, '0, 1'b0);
        branch_op(OP_BGTZ, 32'd1, '0, 1'b1);
        branch_op(OP_BGTZ, 32'd0, '0, 1'b0);
        branch_op(OP_BLTZ, 32'hffff_ffff, '0, 1'b1);
        branch_op(OP_BLTZ, 32'd0, '0, 1'b0);
        branch_op(OP_BGEZ, 32'd0, '0, 1'b1);
        branch_op(OP_BGEZ, 32'hffff_ffff, '0, 1'b0);
        branch_op(OP_JAL, '0, '0, 1'b1);
        branch_op(OP_JR, $random(seed), '0, 1'b1);
        idle_cycles(2);
    endtask

    task automatic load_store_sizes();
        word_t base;
        word_t w;
        word_t sb_data;
        word_t sh_data;
        word_t merged;
        test_name = "load_store";
        base    = 32'h0000_0200;
        w       = $random(seed);
        sb_data = $random(seed);
        sh_data = $random(seed);
        mem_op(OP_SW, base, '0, w, 1'b0, '0);
        mem_op(OP_LW, base, '0, '0, 1'b0, w);
        // 1 KiB further wraps onto the same word of a 256-word ram
        mem_op(OP_LW, base + 32'h400, '0, '0, 1'b0, w);
        for (int off = 0; off < 4; off++) begin
            mem_op(OP_LB, base, off, '0, 1'b0, model_load(OP_LB, w, off));
            mem_op(OP_LBU, base, off, '0, 1'b0, model_load(OP_LBU, w, off));
        end
        for (int off = 0; off < 4; off += 2) begin
            mem_op(OP_LH, base, off, '0, 1'b0, model_load(OP_LH, w, off));
            mem_op(OP_LHU, base, off, '0, 1'b0, model_load(OP_LHU, w, off));
        end
        // byte at offset 1 is bits 23:16, half at offset 2 is bits 15:0
        merged = {w[31:24], sb_data[7:0], sh_data[15:0]};
        mem_op(OP_SB, base, 32'd1, sb_data, 1'b0, '0);
        mem_op(OP_SH, base, 32'd2, sh_data, 1'b0, '0);
        mem_op(OP_LW, base, '0, '0, 1'b0, merged);
        idle_cycles(2);
    endtask

    task automatic misaligned_access();
        word_t base;
        word_t w;
        test_name = "misaligned";
        base = 32'h0000_0300;
        w    = $random(seed);
        mem_op(OP_SW, base, '0, w, 1'b0, '0);
        mem_op(OP_LW, base, 32'd2, '0, 1'b1, '0);
        mem_op(OP_LH, base, 32'd1, '0, 1'b1, '0);
        mem_op(OP_SW, base, 32'd3, ~w, 1'b1, '0);
        // the blocked store must have left the word alone
        mem_op(OP_LW, base, '0, '0, 1'b0, w);
        idle_cycles(2);
    endtask

    task automatic stream_and_reset();
        test_name = "stream";
        for (int k = 0; k < 20; k++)
            random_alu_op();
        idle_cycles(2);
        test_name = "reset";
        reset_sequence();
    endtask

    initial begin
        seed      = 32'hb42ede21;
        cycles    = 0;
        test_name = "reset";
        exp_s0    = '0;
        exp_s1    = '0;
        exp_s2    = '0;
        i_reset   = 1'b1;
        i_valid   = 1'b0;
        i_op      = OP_ADD;
        i_da      = '0;
        i_db      = '0;
        i_imm     = '0;
        i_pc      = '0;
        i_rd      = '0;

        reset_sequence();
        run_alu_ops();
        overflow_cases();
        branch_cases();
        load_store_sizes();
        misaligned_access();
        stream_and_reset();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
